//--- noc_tile.f
+incdir+common
common/noc_pkg.sv
uart_link/uart_phy.sv
switch/flit_buffer.sv
switch/flit_switch.sv
verilog/tile_endpoint.sv
verilog/noc_tile.sv
dv/noc_tile_tb.sv

//--- Makefile
TOP := noc_tile_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f noc_tile.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only -Wall --timing --top-module noc_tile -f noc_tile.f

clean:
	rm -rf obj_dir

//--- dv/noc_tile_tb.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module noc_tile_tb;
    localparam logic [`NOC_NODE_BITS-1:0] NODE_ID = 2'd1;
    localparam int FW = $bits(noc_pkg::flit_t);
    localparam int WATCHDOG_NS = 200 * 22 * `NOC_BAUD_DIV * 20 * 2;

    logic                      clk;
    logic                      arst_n;
    logic [`NOC_NUM_LINKS-1:0] uart_rx;
    logic [`NOC_NUM_LINKS-1:0] uart_tx;
    noc_pkg::bus_req_t         bus_req;
    noc_pkg::bus_rsp_t         bus_rsp;
    logic [`NOC_NUM_LINKS-1:0] frame_err;
    logic [`NOC_NUM_LINKS-1:0] link_drop;

    // Reference model, one queue per destination
    noc_pkg::flit_t exp_local[$];
    noc_pkg::flit_t exp_link[`NOC_NUM_LINKS][$];

    // Error pulses seen on the DUT pins, one bit per link
    logic [`NOC_NUM_LINKS-1:0] frame_err_seen = '0;
    logic [`NOC_NUM_LINKS-1:0] link_drop_seen = '0;

    noc_tile noc_tile_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .node_id  (NODE_ID),
        .uart_rx  (uart_rx),
        .uart_tx  (uart_tx),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .frame_err(frame_err),
        .link_drop(link_drop)
    );

    always #10 clk = ~clk;

    always @(negedge clk) begin
        frame_err_seen = frame_err_seen | frame_err;
        link_drop_seen = link_drop_seen | link_drop;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_flit(input string sig, input noc_pkg::flit_t got,
                              input noc_pkg::flit_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns %s got %h expected %h", $time, sig, got, exp);
            abort_run();
        end
    endtask

    task automatic check_status(input noc_pkg::status_t got, input noc_pkg::status_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns STATUS got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_rdata(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns %s got %h expected %h", $time, sig, got, exp);
            abort_run();
        end
    endtask

    task automatic check_link_bits(input string sig, input logic [`NOC_NUM_LINKS-1:0] got,
                                   input logic [`NOC_NUM_LINKS-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns %s got %b expected %b", $time, sig, got, exp);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // Model
    //////////////////////////////////////////////////
    function automatic int route_port(input noc_pkg::flit_t f);
        if (f.dest == NODE_ID) return 0;
        else return f.dest[0] ? 2 : 1;  // Bit 0 of dest picks the link
    endfunction

    function automatic noc_pkg::flit_t random_flit();
        return noc_pkg::flit_t'(FW'($urandom));
    endfunction

    task automatic expect_flit(input noc_pkg::flit_t f);
        int port;
        port = route_port(f);
        if (port == 0) exp_local.push_back(f);
        else exp_link[port-1].push_back(f);
    endtask

    //////////////////////////////////////////////////
    // Bus and serial drivers
    //////////////////////////////////////////////////
    // All drivers start and end 2 ns after a rising edge
    task automatic bus_write(input noc_pkg::reg_addr_e addr, input logic [31:0] data);
        bus_req.addr  = addr;
        bus_req.wdata = data;
        bus_req.write = 1'b1;
        @(posedge clk);
        #2;
        bus_req.write = 1'b0;
    endtask

    task automatic bus_read(input noc_pkg::reg_addr_e addr, output logic [31:0] data);
        bus_req.addr = addr;
        bus_req.read = 1'b1;
        @(posedge clk);
        #2;
        bus_req.read = 1'b0;
        data = bus_rsp.rdata;  // Registered at the edge just passed
    endtask

    task automatic read_status(output noc_pkg::status_t s);
        logic [31:0] d;
        bus_read(noc_pkg::STATUS, d);
        s = noc_pkg::status_t'(d[7:0]);
    endtask

    task automatic send_local(input noc_pkg::flit_t f);
        noc_pkg::status_t s;
        noc_pkg::flit_t   sent;
        do begin
            read_status(s);
        end while (s.tx_full);
        sent     = f;
        sent.src = NODE_ID;  // The endpoint stamps its own id
        expect_flit(sent);
        bus_write(noc_pkg::TX_FLIT, 32'(f));
    endtask

    task automatic read_rx_check();
        noc_pkg::status_t s;
        logic [31:0]      d;
        do begin
            read_status(s);
        end while (s.rx_count == '0);
        bus_read(noc_pkg::RX_FLIT, d);
        check_rdata("bus_rsp.rdata[31:20]", 32'(d[31:FW]), '0);
        check_flit("RX_FLIT", noc_pkg::flit_t'(d[FW-1:0]), exp_local.pop_front());
    endtask

    task automatic uart_send_frame(input int link, input noc_pkg::flit_t f, input bit bad_stop);
        logic [FW+1:0] frame;
        frame = {~bad_stop, f, 1'b0};  // Start bit goes first, then LSB
        for (int b = 0; b < FW + 2; b++) begin
            uart_rx[link] = frame[b];
            repeat (`NOC_BAUD_DIV) @(posedge clk);
            #2;
        end
        uart_rx[link] = 1'b1;
        repeat (2 * `NOC_BAUD_DIV) @(posedge clk);
        #2;
    endtask

    // Deserializes uart_tx frames, sampling mid-bit on falling edges
    task automatic watch_link(input int link);
        logic [FW-1:0] bits;
        forever begin
            @(negedge clk);
            if (uart_tx[link] === 1'b0) begin
                repeat (`NOC_BAUD_DIV / 2) @(negedge clk);
                for (int b = 0; b < FW; b++) begin
                    repeat (`NOC_BAUD_DIV) @(negedge clk);
                    bits[b] = uart_tx[link];
                end
                repeat (`NOC_BAUD_DIV) @(negedge clk);
                if (uart_tx[link] !== 1'b1) begin
                    $display("Frame on uart_tx[%0d] has a bad stop bit", link);
                    abort_run();
                end else if (exp_link[link].size() == 0) begin
                    $display("Unexpected frame on uart_tx[%0d]", link);
                    abort_run();
                end else begin
                    check_flit($sformatf("uart_tx[%0d]", link), noc_pkg::flit_t'(bits),
                               exp_link[link].pop_front());
                end
            end
        end
    endtask

    task automatic wait_links_idle();
        while (exp_link[0].size() != 0 || exp_link[1].size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        noc_pkg::flit_t            f;
        noc_pkg::status_t          s, exp_s;
        logic [31:0]               d;
        logic [`NOC_NUM_LINKS-1:0] pins;
        clk     = 1'b0;
        arst_n  = 1'b0;
        uart_rx = '1;
        bus_req = '0;
        void'($urandom(54651));
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;
        fork
            watch_link(0);
            watch_link(1);
        join_none

        read_status(s);
        check_status(s, '0);
        check_link_bits("uart_tx", uart_tx, '1);

        // Local loopback
        for (int n = 0; n < `NOC_BUFFER_SIZE; n++) begin
            f      = random_flit();
            f.dest = NODE_ID;
            send_local(f);
        end
        while (exp_local.size() != 0) read_rx_check();

        // Outbound routing
        for (int n = 0; n < 12; n++) begin
            f = random_flit();
            while (f.dest == NODE_ID) f.dest = 2'($urandom);
            send_local(f);
        end
        wait_links_idle();

        // Inbound and transit, one frame at a time so no link input overflows
        for (int n = 0; n < 16; n++) begin
            f = random_flit();
            expect_flit(f);
            uart_send_frame(n % 2, f, 1'b0);
            if (route_port(f) == 0) read_rx_check();
        end
        wait_links_idle();
        check_link_bits("frame_err", frame_err_seen, '0);

        // Frame error
        f      = random_flit();
        f.dest = NODE_ID;
        uart_send_frame(0, f, 1'b1);
        do begin
            read_status(s);
        end while (!s.frame_err);
        exp_s           = '0;
        exp_s.frame_err = 1'b1;
        check_status(s, exp_s);
        pins    = '0;
        pins[0] = 1'b1;  // Only link 0 saw the bad frame
        check_link_bits("frame_err", frame_err_seen, pins);
        bus_read(noc_pkg::RX_FLIT, d);
        check_rdata("bus_rsp.rdata", d, '0);  // Empty read
        bus_write(noc_pkg::STATUS, 32'hff);
        read_status(s);
        check_status(s, '0);

        // Back-pressure
        for (int n = 0; n < `NOC_BUFFER_SIZE + 2; n++) begin
            f      = random_flit();
            f.dest = NODE_ID;
            send_local(f);
        end
        do begin
            read_status(s);
        end while (s.rx_count != 3'(`NOC_BUFFER_SIZE));
        exp_s          = '0;
        exp_s.rx_count = 3'(`NOC_BUFFER_SIZE);
        check_status(s, exp_s);
        while (exp_local.size() != 0) read_rx_check();
        read_status(s);
        check_status(s, '0);
        check_link_bits("link_drop", link_drop_seen, '0);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- verilog/noc_tile.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module noc_tile (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [`NOC_NODE_BITS-1:0]     node_id,   // Strapped
    input  logic [`NOC_NUM_LINKS-1:0]     uart_rx,
    output logic [`NOC_NUM_LINKS-1:0]     uart_tx,
    input  noc_pkg::bus_req_t             bus_req,
    output noc_pkg::bus_rsp_t             bus_rsp,
    output logic [`NOC_NUM_LINKS-1:0]     frame_err,
    output logic [`NOC_NUM_LINKS-1:0]     link_drop
);
    // Switch port 0 is the endpoint, port i+1 is link i
    noc_pkg::flit_t [`NOC_NUM_LINKS:0] sw_in_flit, sw_out_flit;
    logic [`NOC_NUM_LINKS:0]           sw_in_valid, sw_in_ready;
    logic [`NOC_NUM_LINKS:0]           sw_out_valid, sw_out_ready;

    //////////////////////////////////////////////////
    // Serial links
    //////////////////////////////////////////////////
    for (genvar i = 0; i < `NOC_NUM_LINKS; i++) begin : g_link
        uart_phy phy_i (
            .clk      (clk),
            .arst_n   (arst_n),
            .rx       (uart_rx[i]),
            .tx_flit  (sw_out_flit[i+1]),
            .tx_valid (sw_out_valid[i+1]),
            .tx       (uart_tx[i]),
            .tx_ready (sw_out_ready[i+1]),
            .rx_flit  (sw_in_flit[i+1]),
            .rx_valid (sw_in_valid[i+1]),
            .frame_err(frame_err[i])
        );
    end

    flit_switch switch_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .node_id  (node_id),
        .in_flit  (sw_in_flit),
        .in_valid (sw_in_valid),
        .out_ready(sw_out_ready),
        .in_ready (sw_in_ready),
        .out_flit (sw_out_flit),
        .out_valid(sw_out_valid),
        .link_drop(link_drop)
    );

    tile_endpoint endpoint_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .node_id  (node_id),
        .bus_req  (bus_req),
        .inj_ready(sw_in_ready[0]),
        .ej_flit  (sw_out_flit[0]),
        .ej_valid (sw_out_valid[0]),
        .frame_err(frame_err),
        .link_drop(link_drop),
        .bus_rsp  (bus_rsp),
        .inj_flit (sw_in_flit[0]),
        .inj_valid(sw_in_valid[0]),
        .ej_ready (sw_out_ready[0])
    );

endmodule

//--- verilog/tile_endpoint.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module tile_endpoint (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [`NOC_NODE_BITS-1:0]     node_id,
    input  noc_pkg::bus_req_t             bus_req,
    input  logic                          inj_ready,
    input  noc_pkg::flit_t                ej_flit,
    input  logic                          ej_valid,
    input  logic [`NOC_NUM_LINKS-1:0]     frame_err,
    input  logic [`NOC_NUM_LINKS-1:0]     link_drop,
    output noc_pkg::bus_rsp_t             bus_rsp,
    output noc_pkg::flit_t                inj_flit,
    output logic                          inj_valid,
    output logic                          ej_ready
);
    noc_pkg::reg_addr_e addr;
    noc_pkg::flit_t     wr_flit, rx_head;
    noc_pkg::status_t   status, clr;
    logic               wr_tx, rd_rx, rx_not_empty;
    logic [2:0]         rx_count;
    logic               tx_drop_q, link_drop_q, frame_err_q;

    assign addr    = noc_pkg::reg_addr_e'(bus_req.addr);
    assign wr_flit = noc_pkg::flit_t'(bus_req.wdata[$bits(noc_pkg::flit_t)-1:0]);
    assign clr     = noc_pkg::status_t'(bus_req.wdata[7:0]);

    // Injection goes straight into the switch, src is our own id
    assign wr_tx     = bus_req.write && (addr == noc_pkg::TX_FLIT);
    assign inj_valid = wr_tx && inj_ready;
    assign inj_flit  = '{dest: wr_flit.dest, src: node_id, payload: wr_flit.payload};

    assign rd_rx = bus_req.read && (addr == noc_pkg::RX_FLIT) && rx_not_empty;

    flit_buffer rx_buf (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_flit  (ej_flit),
        .wr_en    (ej_valid),
        .rd_en    (rd_rx),
        .rd_flit  (rx_head),
        .ready    (ej_ready),
        .not_empty(rx_not_empty),
        .count    (rx_count)
    );

    assign status = '{rx_count: rx_count, tx_full: !inj_ready, tx_drop: tx_drop_q,
                      link_drop: link_drop_q, frame_err: frame_err_q, spare: 1'b0};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_drop_q     <= 1'b0;
            link_drop_q   <= 1'b0;
            frame_err_q   <= 1'b0;
            bus_rsp.rdata <= '0;
        end else begin
            if (bus_req.write && addr == noc_pkg::STATUS) begin  // Write ones to clear
                tx_drop_q   <= (tx_drop_q & !clr.tx_drop) | (wr_tx && !inj_ready);
                link_drop_q <= (link_drop_q & !clr.link_drop) | (|link_drop);
                frame_err_q <= (frame_err_q & !clr.frame_err) | (|frame_err);
            end else begin
                tx_drop_q   <= tx_drop_q | (wr_tx && !inj_ready);
                link_drop_q <= link_drop_q | (|link_drop);
                frame_err_q <= frame_err_q | (|frame_err);
            end
            bus_rsp.rdata <= '0;
            if (bus_req.read) begin
                case (addr)
                    noc_pkg::RX_FLIT: if (rx_not_empty) bus_rsp.rdata <= 32'(rx_head);
                    noc_pkg::STATUS:  bus_rsp.rdata <= 32'(status);
                    default:          bus_rsp.rdata <= '0;
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) !(bus_req.read && bus_req.write))
        else $error("tile_endpoint: read and write strobes together");

endmodule

//--- switch/flit_switch.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module flit_switch (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic [`NOC_NODE_BITS-1:0]              node_id,
    input  noc_pkg::flit_t [`NOC_NUM_LINKS:0]      in_flit,
    input  logic [`NOC_NUM_LINKS:0]                in_valid,
    input  logic [`NOC_NUM_LINKS:0]                out_ready,
    output logic [`NOC_NUM_LINKS:0]                in_ready,
    output noc_pkg::flit_t [`NOC_NUM_LINKS:0]      out_flit,
    output logic [`NOC_NUM_LINKS:0]                out_valid,
    output logic [`NOC_NUM_LINKS-1:0]              link_drop
);
    localparam int NUM_PORTS = `NOC_NUM_LINKS + 1;
    localparam int PW = $clog2(NUM_PORTS);

    noc_pkg::flit_t [NUM_PORTS-1:0] head;
    logic [NUM_PORTS-1:0]           buf_ready, buf_not_empty, wr_en, rd_en;
    logic [NUM_PORTS-1:0][PW-1:0]   route, gnt_idx, rr_ptr;
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] req, grant;  // [output][input]
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] in_grant;    // [input][output]

    assign in_ready  = buf_ready;
    assign wr_en     = in_valid & buf_ready;
    assign link_drop = in_valid[NUM_PORTS-1:1] & ~buf_ready[NUM_PORTS-1:1];  // Full link input

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in_buf
        flit_buffer buf_i (
            .clk      (clk),
            .arst_n   (arst_n),
            .wr_flit  (in_flit[i]),
            .wr_en    (wr_en[i]),
            .rd_en    (rd_en[i]),
            .rd_flit  (head[i]),
            .ready    (buf_ready[i]),
            .not_empty(buf_not_empty[i]),
            .count    ()
        );
    end

    //////////////////////////////////////////////////
    // Routing and request matrix
    //////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (head[i].dest == node_id) route[i] = PW'(0);   // Local endpoint
            else if (head[i].dest[0])    route[i] = PW'(2);
            else                         route[i] = PW'(1);
            for (int o = 0; o < NUM_PORTS; o++)
                req[o][i] = buf_not_empty[i] && (route[i] == PW'(o));
        end
    end

    // Round-robin search starting at each output's pointer
    always_comb begin : arbitrate
        logic [PW-1:0] idx;
        logic          found;
        grant   = '0;
        gnt_idx = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            found = 1'b0;
            for (int k = 0; k < NUM_PORTS; k++) begin
                idx = PW'((int'(rr_ptr[o]) + k) % NUM_PORTS);
                if (!found && out_ready[o] && req[o][idx]) begin
                    grant[o][idx] = 1'b1;
                    gnt_idx[o]    = idx;
                    found         = 1'b1;
                end
            end
            out_valid[o] = |grant[o];
            out_flit[o]  = head[gnt_idx[o]];
        end
        for (int i = 0; i < NUM_PORTS; i++) begin
            for (int o = 0; o < NUM_PORTS; o++) in_grant[i][o] = grant[o][i];
            rd_en[i] = |in_grant[i];  // Head leaves on grant
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rr_ptr <= '0;
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (out_valid[o])
                    rr_ptr[o] <= (gnt_idx[o] == PW'(NUM_PORTS - 1)) ? '0 : gnt_idx[o] + 1'b1;
            end
        end
    end

    // Port 0 has no drop path, the endpoint must see room before it strobes
    assert property (@(posedge clk) disable iff (!arst_n) in_valid[0] |-> in_ready[0])
        else $error("flit_switch: local flit offered while port 0 buffer is full");

endmodule

//--- switch/flit_buffer.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module flit_buffer (
    input  logic           clk,
    input  logic           arst_n,
    input  noc_pkg::flit_t wr_flit,
    input  logic           wr_en,
    input  logic           rd_en,
    output noc_pkg::flit_t rd_flit,
    output logic           ready,
    output logic           not_empty,
    output logic [2:0]     count
);
    localparam int AW = $clog2(`NOC_BUFFER_SIZE);

    noc_pkg::flit_t mem [`NOC_BUFFER_SIZE];
    logic [AW-1:0]  wr_ptr, rd_ptr;

    assign rd_flit   = mem[rd_ptr];  // Head entry
    assign ready     = (count != 3'(`NOC_BUFFER_SIZE));
    assign not_empty = (count != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= (wr_ptr == AW'(`NOC_BUFFER_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= (rd_ptr == AW'(`NOC_BUFFER_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + 3'(wr_en) - 3'(rd_en);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= wr_flit;
    end

    assert property (@(posedge clk) disable iff (!arst_n) wr_en |-> ready)
        else $error("flit_buffer: write while full");
    assert property (@(posedge clk) disable iff (!arst_n) rd_en |-> not_empty)
        else $error("flit_buffer: read while empty");

endmodule

//--- uart_link/uart_phy.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module uart_phy (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            rx,
    input  noc_pkg::flit_t  tx_flit,
    input  logic            tx_valid,
    output logic            tx,
    output logic            tx_ready,
    output noc_pkg::flit_t  rx_flit,
    output logic            rx_valid,
    output logic            frame_err
);
    localparam int FW = $bits(noc_pkg::flit_t);
    localparam int BW = $clog2(`NOC_BAUD_DIV);

    //////////////////////////////////////////////////
    // Transmitter
    //////////////////////////////////////////////////
    noc_pkg::uart_state_e tx_state;
    logic [BW-1:0]        tx_baud;
    logic [4:0]           tx_bit;
    logic [FW-1:0]        tx_shift;

    assign tx_ready = (tx_state == noc_pkg::IDLE);
    assign tx = (tx_state == noc_pkg::START) ? 1'b0 :
                (tx_state == noc_pkg::DATA)  ? tx_shift[0] : 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_state <= noc_pkg::IDLE;
            tx_baud  <= '0;
            tx_bit   <= '0;
        end else if (tx_state == noc_pkg::IDLE) begin
            tx_baud <= '0;
            if (tx_valid) tx_state <= noc_pkg::START;
        end else if (tx_baud == BW'(`NOC_BAUD_DIV - 1)) begin
            tx_baud <= '0;
            case (tx_state)
                noc_pkg::START: begin
                    tx_state <= noc_pkg::DATA;
                    tx_bit   <= '0;
                end
                noc_pkg::DATA: begin
                    if (tx_bit == 5'(FW - 1)) tx_state <= noc_pkg::STOP;
                    else tx_bit <= tx_bit + 5'd1;
                end
                default: tx_state <= noc_pkg::IDLE;  // End of stop bit
            endcase
        end else begin
            tx_baud <= tx_baud + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_ready && tx_valid) tx_shift <= tx_flit;
        else if (tx_state == noc_pkg::DATA && tx_baud == BW'(`NOC_BAUD_DIV - 1))
            tx_shift <= tx_shift >> 1;  // LSB goes out first
    end

    //////////////////////////////////////////////////
    // Receiver
    //////////////////////////////////////////////////
    noc_pkg::uart_state_e rx_state;
    logic [BW-1:0]        rx_baud;
    logic [4:0]           rx_bit;
    logic [FW-1:0]        rx_shift;
    logic                 rx_meta, rx_sync, rx_prev;

    assign rx_flit = noc_pkg::flit_t'(rx_shift);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta   <= 1'b1;
            rx_sync   <= 1'b1;
            rx_prev   <= 1'b1;
            rx_state  <= noc_pkg::IDLE;
            rx_baud   <= '0;
            rx_bit    <= '0;
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rx_meta   <= rx;
            rx_sync   <= rx_meta;
            rx_prev   <= rx_sync;
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
            rx_baud   <= rx_baud + 1'b1;
            case (rx_state)
                noc_pkg::IDLE: begin
                    rx_baud <= '0;
                    if (rx_prev && !rx_sync) rx_state <= noc_pkg::START;  // Falling edge
                end
                noc_pkg::START: begin
                    // Half a bit in, the line must still be low
                    if (rx_baud == BW'(`NOC_BAUD_DIV / 2 - 1)) begin
                        rx_baud  <= '0;
                        rx_bit   <= '0;
                        rx_state <= rx_sync ? noc_pkg::IDLE : noc_pkg::DATA;
                    end
                end
                noc_pkg::DATA: begin
                    if (rx_baud == BW'(`NOC_BAUD_DIV - 1)) begin
                        rx_bit <= rx_bit + 5'd1;
                        if (rx_bit == 5'(FW - 1)) rx_state <= noc_pkg::STOP;
                    end
                end
                default: begin
                    if (rx_baud == BW'(`NOC_BAUD_DIV - 1)) begin
                        rx_valid  <= rx_sync;
                        frame_err <= !rx_sync;  // Bad stop bit, flit is discarded
                        rx_state  <= noc_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_state == noc_pkg::DATA && rx_baud == BW'(`NOC_BAUD_DIV - 1))
            rx_shift <= {rx_sync, rx_shift[FW-1:1]};
    end

    // The switch must only hand over a flit when the transmitter is idle
    assert property (@(posedge clk) disable iff (!arst_n) tx_valid |-> tx_ready)
        else $error("uart_phy: flit offered while transmitter busy");

endmodule

//--- common/noc_pkg.sv
`include "noc_cfg.svh"

package noc_pkg;

    //////////////////////////////////////////////////
    // Flit and bus types
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [`NOC_NODE_BITS-1:0]    dest;
        logic [`NOC_NODE_BITS-1:0]    src;
        logic [`NOC_PAYLOAD_BITS-1:0] payload;
    } flit_t;

    typedef struct packed {
        logic [3:0]  addr;   // Byte address
        logic        write;
        logic        read;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } bus_rsp_t;

    // STATUS register layout
    typedef struct packed {
        logic [2:0] rx_count;
        logic       tx_full;
        logic       tx_drop;    // Sticky
        logic       link_drop;  // Sticky
        logic       frame_err;  // Sticky
        logic       spare;
    } status_t;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        TX_FLIT = 4'h0,
        RX_FLIT = 4'h4,
        STATUS  = 4'h8
    } reg_addr_e;

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} uart_state_e;

endpackage

//--- common/noc_cfg.svh
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// Tile topology
`define NOC_NUM_LINKS 2
`define NOC_BUFFER_SIZE 4

// Clock cycles per serial bit
`define NOC_BAUD_DIV 4

// Flit field widths
`define NOC_NODE_BITS 2
`define NOC_PAYLOAD_BITS 16

`endif
